// File: commit_pkg.sv
package commit_pkg;

    // ------------------------------------------------------------------
    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [4:0]  areg_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;

    // slot 0 cause vector, bit 6 has the highest priority
    typedef logic [6:0]  exc_cause_t;

    // ------------------------------------------------------------------
    // csr numbers
    parameter csr_num_t CSR_CRMD   = 14'h0;
    parameter csr_num_t CSR_PRMD   = 14'h1;
    parameter csr_num_t CSR_ECFG   = 14'h4;
    parameter csr_num_t CSR_ESTAT  = 14'h5;
    parameter csr_num_t CSR_ERA    = 14'h6;
    parameter csr_num_t CSR_BADV   = 14'h7;
    parameter csr_num_t CSR_EENTRY = 14'hc;
    parameter csr_num_t CSR_CPUID  = 14'h20;

    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_RD,
        CSR_WR,
        CSR_XCHG
    } csr_op_e;

    // cause bit positions
    parameter int CAUSE_INT   = 6;
    parameter int CAUSE_FETCH = 5;
    parameter int CAUSE_SYS   = 4;
    parameter int CAUSE_BRK   = 3;
    parameter int CAUSE_INE   = 2;
    parameter int CAUSE_IPE   = 1;
    parameter int CAUSE_EXEC  = 0;

    // exception codes
    parameter ecode_t ECODE_INT = 6'h0;
    parameter ecode_t ECODE_SYS = 6'hb;
    parameter ecode_t ECODE_BRK = 6'hc;
    parameter ecode_t ECODE_INE = 6'hd;
    parameter ecode_t ECODE_IPE = 6'he;

    // two software lines plus the hardware lines make up ESTAT.IS
    parameter int HW_INT_NUM      = 8;
    parameter int ESTAT_ECODE_LSB = 16;

    // ------------------------------------------------------------------
    // CRMD, raw word for csr access, fields for exception entry
    typedef union packed {
        word_t raw;
        struct packed {
            logic [27:0] rsvd;
            logic        da;
            logic        ie;
            logic [1:0]  plv;
        } f;
    } crmd_u;

    // writable bits per csr
    parameter word_t CRMD_WMASK   = 32'h0000_000f;
    parameter word_t PRMD_WMASK   = 32'h0000_0007;
    parameter word_t ECFG_WMASK   = 32'h0000_03ff;
    parameter word_t ESTAT_WMASK  = 32'h0000_0003;
    // 64-byte aligned entry
    parameter word_t EENTRY_WMASK = 32'hffff_ffc0;

endpackage

// File: commit_select.sv
`timescale 1ns/100ps

module commit_select (
    input  logic                    clk,
    input  logic                    rst_n,
    // per-slot commit info
    input  logic [1:0]              slot_valid_i,
    input  logic [1:0]              solo_i,
    input  logic [1:0]              w_reg_i,
    input  commit_pkg::areg_t [1:0] w_areg_i,
    input  commit_pkg::word_t [1:0] w_data_i,
    // slot 0 only
    input  commit_pkg::word_t       pc_i,
    input  commit_pkg::word_t       va_i,
    input  commit_pkg::ecode_t      exc_code_i,
    input  logic                    fetch_exc_i,
    input  logic                    syscall_i,
    input  logic                    break_i,
    input  logic                    ine_i,
    input  logic                    priv_i,
    input  logic                    exec_exc_i,
    input  commit_pkg::csr_op_e     csr_op_i,
    input  commit_pkg::csr_num_t    csr_num_i,
    input  commit_pkg::word_t       csr_wdata_i,
    input  commit_pkg::word_t       csr_wmask_i,
    // back from csr file and arbiter
    input  logic                    int_pending_i,
    input  logic [1:0]              plv_i,
    input  logic                    hold_i,
    // commit outputs
    output logic                    commit_ready_o,
    output logic [1:0]              commit_request_o,
    output logic [1:0]              arf_we_o,
    output commit_pkg::areg_t [1:0] arf_areg_o,
    output commit_pkg::word_t [1:0] arf_data_o,
    output commit_pkg::csr_op_e     csr_op_o,
    output commit_pkg::csr_num_t    csr_num_o,
    output commit_pkg::word_t       csr_wdata_o,
    output commit_pkg::word_t       csr_wmask_o,
    // to the arbiter
    output commit_pkg::exc_cause_t  cause_o,
    output commit_pkg::word_t       pc_o,
    output commit_pkg::word_t       va_o,
    output commit_pkg::ecode_t      exc_code_o
);
    import commit_pkg::*;

    exc_cause_t cause;
    logic       exc0;
    logic       req0;
    logic       req1;

    // ------------------------------------------------------------------
    // slot 0 causes
    always_comb begin
        cause             = '0;
        cause[CAUSE_INT]   = int_pending_i;
        cause[CAUSE_FETCH] = fetch_exc_i;
        cause[CAUSE_SYS]   = syscall_i;
        cause[CAUSE_BRK]   = break_i;
        cause[CAUSE_INE]   = ine_i;
        // privileged op only faults in user mode
        cause[CAUSE_IPE]   = priv_i & (plv_i == 2'd3);
        cause[CAUSE_EXEC]  = exec_exc_i;
    end

    assign exc0 = |cause;

    // ------------------------------------------------------------------
    // pairing and solo rules
    assign commit_ready_o = ~hold_i;
    assign req0 = slot_valid_i[0] & commit_ready_o;
    assign req1 = req0 & slot_valid_i[1] & ~solo_i[0] & ~solo_i[1] & ~exc0;

    assign commit_request_o = {req1, req0};

    // an exceptional slot 0 writes nothing back
    assign arf_we_o[0] = req0 & w_reg_i[0] & ~exc0;
    assign arf_we_o[1] = req1 & w_reg_i[1];
    assign arf_areg_o  = w_areg_i;
    assign arf_data_o  = w_data_i;

    assign csr_op_o    = (req0 & ~exc0) ? csr_op_i : CSR_NONE;
    assign csr_num_o   = csr_num_i;
    assign csr_wdata_o = csr_wdata_i;
    assign csr_wmask_o = csr_wmask_i;

    // ------------------------------------------------------------------
    // cause capture, cleared on cycles without a commit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cause_o <= '0;
        end else begin
            cause_o <= req0 ? cause : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (req0) begin
            pc_o       <= pc_i;
            va_o       <= va_i;
            exc_code_o <= exc_code_i;
        end
    end

endmodule

// File: exc_arbiter.sv
`timescale 1ns/100ps

module exc_arbiter (
    input  logic                   clk,
    input  logic                   rst_n,
    input  commit_pkg::exc_cause_t cause_i,
    input  commit_pkg::word_t      pc_i,
    input  commit_pkg::word_t      va_i,
    input  commit_pkg::ecode_t     exc_code_i,
    output logic                   flush_o,
    output logic                   exc_we_o,
    output commit_pkg::ecode_t     ecode_o,
    output commit_pkg::word_t      era_o,
    output logic                   badv_we_o,
    output commit_pkg::word_t      badv_o
);
    import commit_pkg::*;

    logic flush_q;
    logic badv_sel;

    // one flush per exceptional commit
    assign exc_we_o = (|cause_i) & ~flush_q;
    assign flush_o  = exc_we_o;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= exc_we_o;
        end
    end

    // ------------------------------------------------------------------
    // priority pick, interrupt first
    always_comb begin
        ecode_o  = ECODE_INT;
        badv_sel = 1'b0;
        if (cause_i[CAUSE_INT]) begin
            ecode_o = ECODE_INT;
        end else if (cause_i[CAUSE_FETCH]) begin
            // fetch side already resolved the code
            ecode_o  = exc_code_i;
            badv_sel = 1'b1;
        end else if (cause_i[CAUSE_SYS]) begin
            ecode_o = ECODE_SYS;
        end else if (cause_i[CAUSE_BRK]) begin
            ecode_o = ECODE_BRK;
        end else if (cause_i[CAUSE_INE]) begin
            ecode_o = ECODE_INE;
        end else if (cause_i[CAUSE_IPE]) begin
            ecode_o = ECODE_IPE;
        end else if (cause_i[CAUSE_EXEC]) begin
            ecode_o  = exc_code_i;
            badv_sel = 1'b1;
        end
    end

    assign era_o     = pc_i;
    assign badv_we_o = exc_we_o & badv_sel;
    assign badv_o    = va_i;

endmodule

// File: csr_file.sv
`timescale 1ns/100ps

module csr_file #(
    parameter int CPU_ID = 0
) (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [commit_pkg::HW_INT_NUM-1:0] hw_int_i,
    // csr instruction from slot 0
    input  commit_pkg::csr_op_e               csr_op_i,
    input  commit_pkg::csr_num_t              csr_num_i,
    input  commit_pkg::word_t                 csr_wdata_i,
    input  commit_pkg::word_t                 csr_wmask_i,
    // exception update
    input  logic                              exc_we_i,
    input  commit_pkg::ecode_t                ecode_i,
    input  commit_pkg::word_t                 era_i,
    input  logic                              badv_we_i,
    input  commit_pkg::word_t                 badv_i,
    output logic                              csr_rdata_valid_o,
    output commit_pkg::word_t                 csr_rdata_o,
    output logic                              int_pending_o,
    output logic [1:0]                        plv_o,
    output commit_pkg::word_t                 eentry_o
);
    import commit_pkg::*;

    localparam int IS_W = HW_INT_NUM + 2;

    crmd_u crmd_q;
    word_t prmd_q;
    word_t ecfg_q;
    word_t estat_q;
    word_t era_q;
    word_t badv_q;
    word_t eentry_q;
    word_t wr_val;
    logic  csr_we;

    function automatic word_t merge(input word_t old, input word_t val, input word_t mask);
        return (old & ~mask) | (val & mask);
    endfunction

    // ------------------------------------------------------------------
    // read side, old value
    always_comb begin
        case (csr_num_i)
            CSR_CRMD:   csr_rdata_o = crmd_q.raw;
            CSR_PRMD:   csr_rdata_o = prmd_q;
            CSR_ECFG:   csr_rdata_o = ecfg_q;
            CSR_ESTAT:  csr_rdata_o = estat_q;
            CSR_ERA:    csr_rdata_o = era_q;
            CSR_BADV:   csr_rdata_o = badv_q;
            CSR_EENTRY: csr_rdata_o = eentry_q;
            CSR_CPUID:  csr_rdata_o = word_t'(CPU_ID);
            default:    csr_rdata_o = '0;
        endcase
    end

    assign csr_rdata_valid_o = (csr_op_i != CSR_NONE);
    assign csr_we = (csr_op_i == CSR_WR) | (csr_op_i == CSR_XCHG);

    // xchg keeps old bits outside wmask
    assign wr_val = (csr_op_i == CSR_WR) ? csr_wdata_i
                  : merge(csr_rdata_o, csr_wdata_i, csr_wmask_i);

    // ------------------------------------------------------------------
    // register update
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            crmd_q      <= '0;
            crmd_q.f.da <= 1'b1;
            prmd_q      <= '0;
            ecfg_q      <= '0;
            estat_q     <= '0;
            era_q       <= '0;
            badv_q      <= '0;
            eentry_q    <= '0;
        end else begin
            if (exc_we_i) begin
                prmd_q[2:0]  <= {crmd_q.f.ie, crmd_q.f.plv};
                crmd_q.f.plv <= 2'd0;
                crmd_q.f.ie  <= 1'b0;
                era_q        <= era_i;
                estat_q[ESTAT_ECODE_LSB +: 6] <= ecode_i;
                if (badv_we_i) begin
                    badv_q <= badv_i;
                end
            end else if (csr_we) begin
                case (csr_num_i)
                    CSR_CRMD:   crmd_q.raw <= merge(crmd_q.raw, wr_val, CRMD_WMASK);
                    CSR_PRMD:   prmd_q     <= merge(prmd_q, wr_val, PRMD_WMASK);
                    CSR_ECFG:   ecfg_q     <= merge(ecfg_q, wr_val, ECFG_WMASK);
                    CSR_ESTAT:  estat_q    <= merge(estat_q, wr_val, ESTAT_WMASK);
                    CSR_ERA:    era_q      <= wr_val;
                    CSR_BADV:   badv_q     <= wr_val;
                    CSR_EENTRY: eentry_q   <= merge(eentry_q, wr_val, EENTRY_WMASK);
                    default:    ;
                endcase
            end
            // hardware lines sampled every cycle
            estat_q[IS_W-1:2] <= hw_int_i;
        end
    end

    // ------------------------------------------------------------------
    // interrupt pending and outputs
    assign int_pending_o = crmd_q.f.ie & (|(estat_q[IS_W-1:0] & ecfg_q[IS_W-1:0]));
    assign plv_o         = crmd_q.f.plv;
    assign eentry_o      = eentry_q;

endmodule

// File: commit_top.sv
`timescale 1ns/100ps

module commit_top #(
    parameter int CPU_ID = 0
) (
    input  logic                              clk,
    input  logic                              rst_n,
    // slot inputs
    input  logic [1:0]                        slot_valid_i,
    input  logic [1:0]                        solo_i,
    input  logic [1:0]                        w_reg_i,
    input  commit_pkg::areg_t [1:0]           w_areg_i,
    input  commit_pkg::word_t [1:0]           w_data_i,
    // slot 0 only
    input  commit_pkg::word_t                 pc_i,
    input  commit_pkg::word_t                 va_i,
    input  commit_pkg::ecode_t                exc_code_i,
    input  logic                              fetch_exc_i,
    input  logic                              syscall_i,
    input  logic                              break_i,
    input  logic                              ine_i,
    input  logic                              priv_i,
    input  logic                              exec_exc_i,
    input  commit_pkg::csr_op_e               csr_op_i,
    input  commit_pkg::csr_num_t              csr_num_i,
    input  commit_pkg::word_t                 csr_wdata_i,
    input  commit_pkg::word_t                 csr_wmask_i,
    input  logic [commit_pkg::HW_INT_NUM-1:0] hw_int_i,
    // outputs
    output logic                              commit_ready_o,
    output logic [1:0]                        commit_request_o,
    output logic [1:0]                        arf_we_o,
    output commit_pkg::areg_t [1:0]           arf_areg_o,
    output commit_pkg::word_t [1:0]           arf_data_o,
    output logic                              csr_rdata_valid_o,
    output commit_pkg::word_t                 csr_rdata_o,
    output logic                              flush_o,
    output commit_pkg::word_t                 redirect_pc_o
);
    import commit_pkg::*;

    csr_op_e    csr_op;
    csr_num_t   csr_num;
    word_t      csr_wdata;
    word_t      csr_wmask;
    exc_cause_t cause_q;
    word_t      pc_q;
    word_t      va_q;
    ecode_t     code_q;
    logic       hold;
    logic       exc_we;
    ecode_t     ecode;
    word_t      era;
    logic       badv_we;
    word_t      badv;
    logic       int_pending;
    logic [1:0] plv;

    // ------------------------------------------------------------------
    // stage 1, slot select and cause capture
    commit_select u_select (
        .clk              (clk),
        .rst_n            (rst_n),
        .slot_valid_i     (slot_valid_i),
        .solo_i           (solo_i),
        .w_reg_i          (w_reg_i),
        .w_areg_i         (w_areg_i),
        .w_data_i         (w_data_i),
        .pc_i             (pc_i),
        .va_i             (va_i),
        .exc_code_i       (exc_code_i),
        .fetch_exc_i      (fetch_exc_i),
        .syscall_i        (syscall_i),
        .break_i          (break_i),
        .ine_i            (ine_i),
        .priv_i           (priv_i),
        .exec_exc_i       (exec_exc_i),
        .csr_op_i         (csr_op_i),
        .csr_num_i        (csr_num_i),
        .csr_wdata_i      (csr_wdata_i),
        .csr_wmask_i      (csr_wmask_i),
        .int_pending_i    (int_pending),
        .plv_i            (plv),
        .hold_i           (hold),
        .commit_ready_o   (commit_ready_o),
        .commit_request_o (commit_request_o),
        .arf_we_o         (arf_we_o),
        .arf_areg_o       (arf_areg_o),
        .arf_data_o       (arf_data_o),
        .csr_op_o         (csr_op),
        .csr_num_o        (csr_num),
        .csr_wdata_o      (csr_wdata),
        .csr_wmask_o      (csr_wmask),
        .cause_o          (cause_q),
        .pc_o             (pc_q),
        .va_o             (va_q),
        .exc_code_o       (code_q)
    );

    // stage 2, arbitration, flush doubles as the hold
    exc_arbiter u_arbiter (
        .clk        (clk),
        .rst_n      (rst_n),
        .cause_i    (cause_q),
        .pc_i       (pc_q),
        .va_i       (va_q),
        .exc_code_i (code_q),
        .flush_o    (hold),
        .exc_we_o   (exc_we),
        .ecode_o    (ecode),
        .era_o      (era),
        .badv_we_o  (badv_we),
        .badv_o     (badv)
    );

    // stage 3, csr file
    csr_file #(
        .CPU_ID (CPU_ID)
    ) u_csr (
        .clk               (clk),
        .rst_n             (rst_n),
        .hw_int_i          (hw_int_i),
        .csr_op_i          (csr_op),
        .csr_num_i         (csr_num),
        .csr_wdata_i       (csr_wdata),
        .csr_wmask_i       (csr_wmask),
        .exc_we_i          (exc_we),
        .ecode_i           (ecode),
        .era_i             (era),
        .badv_we_i         (badv_we),
        .badv_i            (badv),
        .csr_rdata_valid_o (csr_rdata_valid_o),
        .csr_rdata_o       (csr_rdata_o),
        .int_pending_o     (int_pending),
        .plv_o             (plv),
        .eentry_o          (redirect_pc_o)
    );

    assign flush_o = hold;

endmodule

// File: commit_props.sv
`timescale 1ns/100ps

module commit_props (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush_i,
    input  logic [1:0]             commit_request_i,
    input  logic [1:0]             arf_we_i,
    input  commit_pkg::exc_cause_t cause_i
);

    // ------------------------------------------------------------------
    // flush protocol
    flush_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) flush_i |=> !flush_i
    ) else $error("flush_o stayed high for two cycles");

    flush_blocks_commit: assert property (
        @(posedge clk) disable iff (!rst_n) flush_i |-> (commit_request_i == 2'b00)
    ) else $error("commit request made while flush_o was high");

    // ------------------------------------------------------------------
    // request and write-back rules
    pair_needs_slot0: assert property (
        @(posedge clk) disable iff (!rst_n) commit_request_i[1] |-> commit_request_i[0]
    ) else $error("slot 1 requested without slot 0");

    // cause_q is nonzero only in the cycle after an exceptional commit
    no_write_after_exc: assert property (
        @(posedge clk) disable iff (!rst_n) (|cause_i) |-> !arf_we_i[0]
    ) else $error("slot 0 register write right after an exceptional commit");

endmodule

bind commit_top commit_props u_props (
    .clk              (clk),
    .rst_n            (rst_n),
    .flush_i          (flush_o),
    .commit_request_i (commit_request_o),
    .arf_we_i         (arf_we_o),
    .cause_i          (cause_q)
);

// File: tb_commit_top.sv
`timescale 1ns/100ps

module tb_commit_top;
    import commit_pkg::*;

    parameter int SEED = 92;

    localparam int CPU_ID          = 5;
    localparam int CLK_PERIOD      = 20;
    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 40;

    logic                      clk;
    logic                      rst_n;
    logic [1:0]                slot_valid;
    logic [1:0]                solo;
    logic [1:0]                w_reg;
    areg_t [1:0]               w_areg;
    word_t [1:0]               w_data;
    word_t                     pc;
    word_t                     va;
    ecode_t                    exc_code;
    logic                      fetch_exc;
    logic                      syscall;
    logic                      brk_exc;
    logic                      ine;
    logic                      priv;
    logic                      exec_exc;
    csr_op_e                   csr_op;
    csr_num_t                  csr_num;
    word_t                     csr_wdata;
    word_t                     csr_wmask;
    logic [HW_INT_NUM-1:0]     hw_int;

    logic                      commit_ready_o;
    logic [1:0]                commit_request_o;
    logic [1:0]                arf_we_o;
    areg_t [1:0]               arf_areg_o;
    word_t [1:0]               arf_data_o;
    logic                      csr_rdata_valid_o;
    word_t                     csr_rdata_o;
    logic                      flush_o;
    word_t                     redirect_pc_o;

    // reference copy of the CSR state
    word_t  m_crmd = 32'h0000_0008;
    word_t  m_prmd = '0;
    word_t  m_ecfg = '0;
    word_t  m_era = '0;
    word_t  m_badv = '0;
    word_t  m_eentry = '0;
    ecode_t m_ecode = '0;

    commit_top #(
        .CPU_ID (CPU_ID)
    ) dut_i (
        .clk (clk), .rst_n (rst_n),
        .slot_valid_i (slot_valid), .solo_i (solo), .w_reg_i (w_reg),
        .w_areg_i (w_areg), .w_data_i (w_data),
        .pc_i (pc), .va_i (va), .exc_code_i (exc_code),
        .fetch_exc_i (fetch_exc), .syscall_i (syscall), .break_i (brk_exc),
        .ine_i (ine), .priv_i (priv), .exec_exc_i (exec_exc),
        .csr_op_i (csr_op), .csr_num_i (csr_num),
        .csr_wdata_i (csr_wdata), .csr_wmask_i (csr_wmask), .hw_int_i (hw_int),
        .commit_ready_o (commit_ready_o), .commit_request_o (commit_request_o),
        .arf_we_o (arf_we_o), .arf_areg_o (arf_areg_o), .arf_data_o (arf_data_o),
        .csr_rdata_valid_o (csr_rdata_valid_o), .csr_rdata_o (csr_rdata_o),
        .flush_o (flush_o), .redirect_pc_o (redirect_pc_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------------------------------------------
    // checking helpers
    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("ERROR at %0t: %s", $time, what);
            $display("*** FAILED ***");
            $fatal(1, "check failed");
        end
    endtask

    // ------------------------------------------------------------------
    // CSR reference model
    function automatic word_t field_mask(input csr_num_t num);
        case (num)
            CSR_CRMD:   return CRMD_WMASK;
            CSR_PRMD:   return PRMD_WMASK;
            CSR_ECFG:   return ECFG_WMASK;
            CSR_EENTRY: return EENTRY_WMASK;
            default:    return 32'hffff_ffff;
        endcase
    endfunction

    function automatic word_t model_read(input csr_num_t num);
        case (num)
            CSR_CRMD:   return m_crmd;
            CSR_PRMD:   return m_prmd;
            CSR_ECFG:   return m_ecfg;
            CSR_ERA:    return m_era;
            CSR_BADV:   return m_badv;
            CSR_EENTRY: return m_eentry;
            CSR_CPUID:  return 32'(CPU_ID);
            default:    return '0;
        endcase
    endfunction

    // xchg takes wdata under wmask, then only writable fields change
    function automatic word_t next_csr_value(input csr_op_e op, input word_t old,
                                             input word_t wdata, input word_t wmask,
                                             input word_t fmask);
        word_t val;
        val = (op == CSR_XCHG) ? ((wdata & wmask) | (old & ~wmask)) : wdata;
        return (old & ~fmask) | (val & fmask);
    endfunction

    task automatic store_model(input csr_num_t num, input word_t val);
        case (num)
            CSR_CRMD:   m_crmd = val;
            CSR_PRMD:   m_prmd = val;
            CSR_ECFG:   m_ecfg = val;
            CSR_ERA:    m_era = val;
            CSR_BADV:   m_badv = val;
            CSR_EENTRY: m_eentry = val;
            default:    ;
        endcase
    endtask

    // ------------------------------------------------------------------
    // stimulus tasks
    task automatic clear_inputs();
        slot_valid <= '0;
        solo       <= '0;
        w_reg      <= '0;
        w_areg     <= '0;
        w_data     <= '0;
        {fetch_exc, syscall, brk_exc, ine, priv, exec_exc} <= 6'b0;
        csr_op     <= CSR_NONE;
        csr_num    <= '0;
        csr_wdata  <= '0;
        csr_wmask  <= '0;
    endtask

    task automatic csr_access(input csr_op_e op, input csr_num_t num, input word_t wdata,
                              input word_t wmask, output word_t rdata);
        @(posedge clk);
        slot_valid <= 2'b01;
        csr_op     <= op;
        csr_num    <= num;
        csr_wdata  <= wdata;
        csr_wmask  <= wmask;
        @(negedge clk);
        check_true(commit_request_o[0] & csr_rdata_valid_o, "CSR instruction was not committed");
        rdata = csr_rdata_o;
        @(posedge clk);
        clear_inputs();
    endtask

    task automatic csr_write(input csr_op_e op, input csr_num_t num, input word_t wdata,
                             input word_t wmask);
        word_t old;
        csr_access(op, num, wdata, wmask, old);
        check_word("csr_rdata_o", old, model_read(num));
        store_model(num, next_csr_value(op, model_read(num), wdata, wmask, field_mask(num)));
    endtask

    task automatic csr_read_check(input string name, input csr_num_t num);
        word_t rd;
        csr_access(CSR_RD, num, '0, '0, rd);
        check_word(name, rd, model_read(num));
    endtask

    task automatic check_exc_state();
        word_t rd;
        csr_read_check("CRMD", CSR_CRMD);
        csr_read_check("PRMD", CSR_PRMD);
        csr_read_check("ERA", CSR_ERA);
        csr_read_check("BADV", CSR_BADV);
        csr_access(CSR_RD, CSR_ESTAT, '0, '0, rd);
        check_word("ESTAT.ECODE", 32'(rd[ESTAT_ECODE_LSB +: 6]), 32'(m_ecode));
    endtask

    // flags are {fetch, syscall, break, ine, priv, exec}
    task automatic exc_commit(input logic [5:0] flags, input ecode_t code,
                              input ecode_t exp_ecode, input logic exp_badv);
        word_t pc_v;
        word_t va_v;
        word_t d0;
        pc_v = $urandom;
        va_v = $urandom;
        d0 = $urandom;
        @(posedge clk);
        slot_valid <= 2'b11;
        w_reg      <= 2'b11;
        w_data     <= {d0, d0};
        pc         <= pc_v;
        va         <= va_v;
        exc_code   <= code;
        {fetch_exc, syscall, brk_exc, ine, priv, exec_exc} <= flags;
        @(negedge clk);
        check_word("commit_request_o", 32'(commit_request_o), 32'h1);
        check_word("arf_we_o", 32'(arf_we_o), 32'h0);
        check_word("flush_o", 32'(flush_o), 32'h0);
        // slots stay valid so the hold is visible
        @(posedge clk);
        {fetch_exc, syscall, brk_exc, ine, priv, exec_exc} <= 6'b0;
        @(negedge clk);
        check_word("flush_o", 32'(flush_o), 32'h1);
        check_word("commit_ready_o", 32'(commit_ready_o), 32'h0);
        check_word("commit_request_o", 32'(commit_request_o), 32'h0);
        check_word("redirect_pc_o", redirect_pc_o, m_eentry);
        @(posedge clk);
        clear_inputs();
        // PRMD.PIE/PPLV and CRMD.IE/PLV share bit positions
        m_prmd = (m_prmd & ~32'h7) | (m_crmd & 32'h7);
        m_crmd = m_crmd & ~32'h7;
        m_era = pc_v;
        m_ecode = exp_ecode;
        if (exp_badv) begin
            m_badv = va_v;
        end
    endtask

    task automatic single_commit();
        word_t d0;
        word_t tmp;
        d0 = $urandom;
        tmp = $urandom;
        @(posedge clk);
        slot_valid <= 2'b01;
        w_reg      <= 2'b01;
        w_areg     <= {5'd0, tmp[4:0]};
        w_data     <= {32'h0, d0};
        @(negedge clk);
        check_word("commit_request_o", 32'(commit_request_o), 32'h1);
        check_word("arf_we_o", 32'(arf_we_o), 32'h1);
        check_word("arf_areg_o[0]", 32'(arf_areg_o[0]), 32'(tmp[4:0]));
        check_word("arf_data_o[0]", arf_data_o[0], d0);
        @(posedge clk);
        clear_inputs();
        @(negedge clk);
        check_word("flush_o", 32'(flush_o), 32'h0);
    endtask

    // ------------------------------------------------------------------
    // tests
    task automatic test_pairing();
        word_t d0;
        word_t d1;
        word_t tmp;
        d0 = $urandom;
        d1 = $urandom;
        tmp = $urandom;
        @(posedge clk);
        slot_valid <= 2'b11;
        w_reg      <= 2'b11;
        w_areg     <= {tmp[9:5], tmp[4:0]};
        w_data     <= {d1, d0};
        @(negedge clk);
        check_word("commit_request_o", 32'(commit_request_o), 32'h3);
        check_word("arf_we_o", 32'(arf_we_o), 32'h3);
        check_word("arf_areg_o[0]", 32'(arf_areg_o[0]), 32'(tmp[4:0]));
        check_word("arf_areg_o[1]", 32'(arf_areg_o[1]), 32'(tmp[9:5]));
        check_word("arf_data_o[0]", arf_data_o[0], d0);
        check_word("arf_data_o[1]", arf_data_o[1], d1);
        @(posedge clk);
        solo <= 2'b01;
        @(negedge clk);
        check_word("commit_request_o", 32'(commit_request_o), 32'h1);
        @(posedge clk);
        solo <= 2'b10;
        @(negedge clk);
        check_word("commit_request_o", 32'(commit_request_o), 32'h1);
        @(posedge clk);
        clear_inputs();
    endtask

    task automatic test_csr();
        word_t r0;
        word_t r1;
        r0 = $urandom;
        csr_write(CSR_WR, CSR_EENTRY, r0, '0);
        csr_read_check("EENTRY", CSR_EENTRY);
        r0 = $urandom;
        csr_write(CSR_WR, CSR_ECFG, r0, '0);
        csr_read_check("ECFG", CSR_ECFG);
        r0 = $urandom;
        r1 = $urandom;
        csr_write(CSR_XCHG, CSR_ECFG, r0, r1);
        csr_read_check("ECFG", CSR_ECFG);
        csr_write(CSR_XCHG, CSR_CRMD, 32'hffff_fff5, 32'h0000_0006);
        csr_read_check("CRMD", CSR_CRMD);
        csr_read_check("CPUID", CSR_CPUID);
        csr_read_check("unknown CSR", 14'h3f);
    endtask

    task automatic test_syscall();
        // PLV 3 with IE set, so PRMD has something to save
        csr_write(CSR_WR, CSR_CRMD, 32'h0000_0007, '0);
        exc_commit(6'b010000, 6'h0, ECODE_SYS, 1'b0);
        check_exc_state();
    endtask

    task automatic test_priority();
        word_t tmp;
        tmp = $urandom;
        exc_commit(6'b110000, tmp[5:0], tmp[5:0], 1'b1);
        check_exc_state();
        exc_commit(6'b001100, 6'h0, ECODE_BRK, 1'b0);
        check_exc_state();
        csr_write(CSR_WR, CSR_CRMD, 32'h0000_0003, '0);
        exc_commit(6'b000010, 6'h0, ECODE_IPE, 1'b0);
        check_exc_state();
    endtask

    task automatic test_interrupt();
        // LIE bit 2 maps to hardware line 0
        csr_write(CSR_WR, CSR_ECFG, 32'h0000_0004, '0);
        csr_write(CSR_WR, CSR_CRMD, 32'h0000_0004, '0);
        @(posedge clk);
        hw_int <= 8'h01;
        @(posedge clk);
        exc_commit(6'b000000, 6'h0, ECODE_INT, 1'b0);
        check_exc_state();
        // entry cleared IE, line still high
        single_commit();
        @(posedge clk);
        hw_int <= '0;
    endtask

    // ------------------------------------------------------------------
    // watchdog
    initial begin
        #(CLK_PERIOD * (4 + CYCLES_PER_TEST * NUM_TESTS));
        $display("ERROR: run did not finish within the cycle budget");
        $display("*** FAILED ***");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        void'($urandom(SEED));
        rst_n = 1'b0;
        slot_valid = '0;
        solo = '0;
        w_reg = '0;
        w_areg = '0;
        w_data = '0;
        pc = '0;
        va = '0;
        exc_code = '0;
        {fetch_exc, syscall, brk_exc, ine, priv, exec_exc} = 6'b0;
        csr_op = CSR_NONE;
        csr_num = '0;
        csr_wdata = '0;
        csr_wmask = '0;
        hw_int = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_word("flush_o", 32'(flush_o), 32'h0);
        check_word("commit_request_o", 32'(commit_request_o), 32'h0);
        check_word("arf_we_o", 32'(arf_we_o), 32'h0);
        check_word("csr_rdata_valid_o", 32'(csr_rdata_valid_o), 32'h0);
        test_pairing();
        test_csr();
        test_syscall();
        test_priority();
        test_interrupt();
        @(posedge clk);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: commit_top.f
commit_pkg.sv
commit_select.sv
exc_arbiter.sv
csr_file.sv
commit_top.sv
commit_props.sv
tb_commit_top.sv

// File: Makefile
# Verilator build and run of the commit stage testbench

VERILATOR ?= verilator
TOP       ?= tb_commit_top
SEED      ?= 92
FLAGS     ?= --timing --assert
FILELIST  := commit_top.f
OBJ_DIR   := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(FLAGS) -GSEED=$(SEED) --top-module $(TOP) \
		-f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# the simulator exits non-zero on $fatal or a failed assertion
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
